// ==== build.f ====
source/rv_isa_pkg.sv
source/rv_csr_pkg.sv
source/inst_queue.sv
source/issue_register.sv
source/load_interlock.sv
source/inst_classifier.sv
source/operand_read.sv
source/decode_unit.sv
verif/decode_asserts.sv
verif/decode_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module decode_tb
./obj_dir/Vdecode_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"

// ==== verif/decode_tb.sv ====
module decode_tb
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
();

    localparam int queue_depth = 16;
    localparam int almost_full_level = 12;
    localparam int num_items = 400;
    localparam int reset_cycles = 8;
    localparam int watchdog_cycles = reset_cycles + 40 * num_items;

    logic clk, reset, flush;
    logic in_valid, in_ready, out_valid, out_ready;
    addr_t in_pc, out_pc;
    inst_t in_inst, out_inst, ex_inst;
    op_class_t op_class;
    reg_idx_t rd, rs1, rs2, wb_addr;
    funct3_t funct3;
    logic [xlen-1:0] imm, src_a, src_b, wb_data;
    logic [xlen-1:0] mstatus, mtvec, mepc, mcause;
    logic ex_valid, wb_en;

    addr_t model_pc [$];   // accepted and not yet transferred
    inst_t model_inst [$];
    logic [xlen-1:0] model_regs [reg_count];
    // index matches the class bit for the first eleven
    opcode_t major_opcodes [12] = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
        opc_load, opc_store, opc_op_imm, opc_op, opc_op_imm32, opc_op32, opc_system};
    csr_addr_t csr_list [4] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause};
    integer seed = 32'he4b1;
    string test_name;
    logic draining;
    logic in_pending;   // fetch holds an item not yet taken
    int accepted, checks, errors, test_errors, tests_done;

    decode_unit #(
        .queue_depth(queue_depth),
        .almost_full_level(almost_full_level)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic op_class_t expected_class(input inst_t inst);
        op_class_t c;
        c = '0;
        for (int i = 0; i < 11; i++) begin
            if (inst[6:0] == major_opcodes[i]) c[i] = 1'b1;
        end
        if (inst[6:0] == opc_system) begin
            c[cls_csr] = (inst[14:12] != 3'b000);
            c[cls_ebreak] = (inst == inst_ebreak);
            c[cls_ecall] = (inst == inst_ecall);
            c[cls_mret] = (inst == inst_mret);
        end
        return c;
    endfunction

    function automatic logic [xlen-1:0] expected_imm(input inst_t inst);
        op_class_t c;
        logic [31:0] raw;   // 32-bit form before widening
        c = expected_class(inst);
        if (c[cls_lui] || c[cls_auipc]) raw = {inst[31:12], 12'h000};
        else if (c[cls_jal]) raw = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
        else if (c[cls_branch]) raw = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                       inst[11:8], 1'b0};
        else if (c[cls_store]) raw = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        else raw = {{20{inst[31]}}, inst[31:20]};
        return {{32{raw[31]}}, raw};
    endfunction

    function automatic logic [xlen-1:0] reg_value(input reg_idx_t idx);
        return (idx == 5'd0) ? '0 : model_regs[idx];
    endfunction

    function automatic logic [xlen-1:0] expected_src_b(input inst_t inst);
        op_class_t c;
        c = expected_class(inst);
        if (c[cls_ecall]) return mtvec;
        if (c[cls_mret]) return mepc;
        if (!c[cls_csr]) return reg_value(inst[24:20]);
        if (inst[31:20] == csr_mstatus) return mstatus;
        if (inst[31:20] == csr_mtvec) return mtvec;
        if (inst[31:20] == csr_mepc) return mepc;
        if (inst[31:20] == csr_mcause) return mcause;
        return '0;   // unmapped csr address
    endfunction

    function automatic logic load_hazard(input inst_t held, input inst_t ex);
        op_class_t c;
        logic rs2_read;
        c = expected_class(held);
        rs2_read = c[cls_jal] | c[cls_jalr] | c[cls_branch] | c[cls_alu_r] | c[cls_alu_rw];
        return (ex[6:0] == opc_load) &&
               ((ex[11:7] == held[19:15]) || ((ex[11:7] == held[24:20]) && rs2_read));
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR %s: %s", test_name, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    task automatic make_inst(output inst_t inst);
        logic [31:0] r;
        r = $random(seed);
        inst = $random(seed);
        inst[11:7] = {2'b00, inst[9:7]};   // few registers give more hazards
        inst[19:15] = {2'b00, inst[17:15]};
        inst[24:20] = {2'b00, inst[22:20]};
        if (r[3:0] < 4'd9) begin
            inst[6:0] = major_opcodes[r[7:4] % 4'd12];
            if (inst[6:0] == opc_system && r[8]) inst[31:20] = csr_list[r[10:9]];
        end else if (r[3:0] < 4'd11) begin
            inst = (r[5:4] == 2'b00) ? inst_ecall : (r[5:4] == 2'b01) ? inst_ebreak : inst_mret;
        end else if (r[3:0] == 4'd11) begin
            inst[1:0] = 2'b00;   // no major opcode ends in 00
        end else begin
            inst[6:0] = opc_load;
            inst[11:7] = {2'b00, r[14:12]};
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        inst_t inst;
        r = $random(seed);
        flush = !draining && (r[4:0] == 5'd0);
        out_ready = draining || (!flush && r[7]);
        wb_en = r[8];
        wb_addr = {2'b00, r[11:9]};
        wb_data = {$random(seed), $random(seed)};
        if (draining || flush) begin
            in_valid = 1'b0;
        end else if (!in_pending) begin
            make_inst(inst);
            in_valid = (r[6:5] != 2'b00);
            in_pc = {$random(seed), $random(seed)};
            in_inst = inst;
        end
        if (draining) begin
            ex_valid = 1'b0;
        end else if (r[13:12] == 2'b00) begin   // ex changes now and then
            make_inst(inst);
            ex_valid = r[14];
            ex_inst = inst;
            if (r[15]) ex_inst[6:0] = opc_load;
        end
    endtask

    task automatic sample_outputs();
        addr_t pc;
        inst_t inst;
        if (!in_ready) begin
            check_true(model_pc.size() >= almost_full_level,
                       "in_ready fell before 12 items were outstanding");
        end
        if (out_valid) begin
            check_true(model_pc.size() > 0, "out_valid high with no item outstanding");
            check_true(!(ex_valid && model_inst.size() > 0 && load_hazard(model_inst[0], ex_inst)),
                       "out_valid high during a load-use hazard");
        end
        if (out_valid && out_ready && model_pc.size() > 0) begin
            pc = model_pc.pop_front();
            inst = model_inst.pop_front();
            check_value("out_pc", pc, out_pc);
            check_value("out_inst", 64'(inst), 64'(out_inst));
            check_value("op_class", 64'(expected_class(inst)), 64'(op_class));
            check_value("rd", 64'(inst[11:7]), 64'(rd));
            check_value("rs1", 64'(inst[19:15]), 64'(rs1));
            check_value("rs2", 64'(inst[24:20]), 64'(rs2));
            check_value("funct3", 64'(inst[14:12]), 64'(funct3));
            check_value("imm", expected_imm(inst), imm);
            check_value("src_a", reg_value(inst[19:15]), src_a);
            check_value("src_b", expected_src_b(inst), src_b);
        end
        if (in_valid && in_ready) begin
            model_pc.push_back(in_pc);
            model_inst.push_back(in_inst);
            accepted++;
        end
        in_pending = in_valid && !in_ready;
        if (wb_en) model_regs[wb_addr] = wb_data;   // seen from the next cycle
        if (flush) begin
            model_pc.delete();
            model_inst.delete();
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #2;
        drive_inputs();
        #16;   // outputs settled before the edge
        sample_outputs();
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        out_ready = 1'b0;
        ex_valid = 1'b0;
        ex_inst = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        draining = 1'b0;
        in_pending = 1'b0;
        mstatus = {$random(seed), $random(seed)};
        mtvec = {$random(seed), $random(seed)};
        mepc = {$random(seed), $random(seed)};
        mcause = {$random(seed), $random(seed)};
        for (int i = 0; i < reg_count; i++) model_regs[i] = '0;
        test_name = "reset";
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        #16;
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("in_ready", 64'd1, 64'(in_ready));
        end_test();
        test_name = "random_traffic";
        while (accepted < num_items) run_cycle();
        end_test();
        test_name = "drain";
        draining = 1'b1;
        while (model_pc.size() > 0) run_cycle();
        run_cycle();
        check_value("out_valid", 64'd0, 64'(out_valid));
        end_test();
        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests_done, checks, errors, DUT.asserts_i.failures);
        if (errors == 0 && DUT.asserts_i.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 20);
        $display("ERROR watchdog: run still busy after %0d cycles, %0d items outstanding",
                 watchdog_cycles, model_pc.size());
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verif/decode_asserts.sv ====
module decode_asserts
    import rv_isa_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            flush,
    input logic            out_valid,
    input logic            out_ready,
    input addr_t           out_pc,
    input inst_t           out_inst,
    input op_class_t       op_class,
    input logic [xlen-1:0] imm,
    input logic            ex_valid,
    input inst_t           ex_inst
);

    int failures = 0;
    logic rs2_read;
    logic hazard;

    assign rs2_read = op_class[cls_jal] || op_class[cls_jalr] || op_class[cls_branch] ||
                      op_class[cls_alu_r] || op_class[cls_alu_rw];
    assign hazard = ex_valid && (ex_inst[6:0] == opc_load) &&
                    ((ex_inst[11:7] == out_inst[19:15]) ||
                     ((ex_inst[11:7] == out_inst[24:20]) && rs2_read));

    valid_low_after_clear: assert property (@(posedge clk) (reset || flush) |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset or flush");
            failures++;
        end

    // decode outputs hold while execute stalls
    stable_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready && !flush) |=>
        ($stable(out_pc) && $stable(out_inst) && $stable(op_class) && $stable(imm)))
        else begin
            $error("decode outputs changed while out_valid high and out_ready low");
            failures++;
        end

    no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
        !(out_valid && hazard))
        else begin
            $error("out_valid high while a load-use hazard is present");
            failures++;
        end

endmodule

bind decode_unit decode_asserts asserts_i (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_pc(out_pc),
    .out_inst(out_inst),
    .op_class(op_class),
    .imm(imm),
    .ex_valid(ex_valid),
    .ex_inst(ex_inst)
);

// ==== source/decode_unit.sv ====
module decode_unit
    import rv_isa_pkg::*;
#(
    parameter int queue_depth = 16,
    parameter int almost_full_level = 12
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            in_valid,
    output logic            in_ready,
    input  addr_t           in_pc,
    input  inst_t           in_inst,
    output logic            out_valid,
    input  logic            out_ready,
    output addr_t           out_pc,
    output inst_t           out_inst,
    output op_class_t       op_class,
    output reg_idx_t        rd,
    output reg_idx_t        rs1,
    output reg_idx_t        rs2,
    output funct3_t         funct3,
    output logic [xlen-1:0] imm,
    output logic [xlen-1:0] src_a,
    output logic [xlen-1:0] src_b,
    input  logic            ex_valid,
    input  inst_t           ex_inst,
    input  logic            wb_en,
    input  reg_idx_t        wb_addr,
    input  logic [xlen-1:0] wb_data,
    input  logic [xlen-1:0] mstatus,
    input  logic [xlen-1:0] mtvec,
    input  logic [xlen-1:0] mepc,
    input  logic [xlen-1:0] mcause
);

    logic queue_clear;
    logic in_accept;
    logic queue_write;
    logic queue_read;
    logic queue_almost_full;
    logic queue_empty;
    addr_t queue_pc;
    inst_t queue_inst;
    logic held_valid;
    logic block;
    logic advance;

    assign queue_clear = reset || flush;
    assign in_ready = !queue_almost_full;   // slack covers items in flight
    assign in_accept = in_valid && in_ready;
    assign advance = out_ready && !block;
    assign out_valid = held_valid && !block;

    inst_queue #(
        .payload_t(addr_t),
        .queue_depth(queue_depth),
        .almost_full_level(almost_full_level)
    ) pc_queue (
        .clk(clk),
        .reset(queue_clear),
        .write(queue_write),
        .write_data(in_pc),
        .read(queue_read),
        .read_data(queue_pc),
        .almost_full(queue_almost_full),
        .empty(queue_empty)
    );

    // same controls as pc_queue, so its flags are identical
    inst_queue #(
        .payload_t(inst_t),
        .queue_depth(queue_depth),
        .almost_full_level(almost_full_level)
    ) inst_queue_i (
        .clk(clk),
        .reset(queue_clear),
        .write(queue_write),
        .write_data(in_inst),
        .read(queue_read),
        .read_data(queue_inst),
        .almost_full(),
        .empty()
    );

    issue_register issue_register_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .in_valid(in_accept),
        .in_pc(in_pc),
        .in_inst(in_inst),
        .queue_empty(queue_empty),
        .queue_pc(queue_pc),
        .queue_inst(queue_inst),
        .advance(advance),
        .queue_write(queue_write),
        .queue_read(queue_read),
        .held_valid(held_valid),
        .held_pc(out_pc),
        .held_inst(out_inst)
    );

    load_interlock load_interlock_i (
        .held_valid(held_valid),
        .held_inst(out_inst),
        .held_class(op_class),
        .ex_valid(ex_valid),
        .ex_inst(ex_inst),
        .block(block)
    );

    inst_classifier inst_classifier_i (
        .held_valid(held_valid),
        .held_inst(out_inst),
        .op_class(op_class),
        .rd(rd),
        .rs1(rs1),
        .rs2(rs2),
        .funct3(funct3),
        .imm(imm)
    );

    operand_read operand_read_i (
        .clk(clk),
        .reset(reset),
        .wb_en(wb_en),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .rs1(rs1),
        .rs2(rs2),
        .csr_addr(out_inst[31:20]),   // csr field of i format
        .op_class(op_class),
        .mstatus(mstatus),
        .mtvec(mtvec),
        .mepc(mepc),
        .mcause(mcause),
        .src_a(src_a),
        .src_b(src_b)
    );

endmodule

// ==== source/operand_read.sv ====
module operand_read
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            wb_en,
    input  reg_idx_t        wb_addr,
    input  logic [xlen-1:0] wb_data,
    input  reg_idx_t        rs1,
    input  reg_idx_t        rs2,
    input  csr_addr_t       csr_addr,
    input  op_class_t       op_class,
    input  logic [xlen-1:0] mstatus,
    input  logic [xlen-1:0] mtvec,
    input  logic [xlen-1:0] mepc,
    input  logic [xlen-1:0] mcause,
    output logic [xlen-1:0] src_a,
    output logic [xlen-1:0] src_b
);

    logic [xlen-1:0] regs [reg_count];
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] csr_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;   // visible to reads after this edge
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];   // x0 hardwired
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_value = mstatus;
            csr_mtvec: csr_value = mtvec;
            csr_mepc: csr_value = mepc;
            csr_mcause: csr_value = mcause;
            default: csr_value = '0;   // unmapped csr
        endcase
    end

    assign src_a = rs1_value;
    assign src_b = op_class[cls_csr]   ? csr_value :
                   op_class[cls_ecall] ? mtvec :   // trap target
                   op_class[cls_mret]  ? mepc :   // return address
                                         rs2_value;

endmodule

// ==== source/inst_classifier.sv ====
module inst_classifier
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic            held_valid,
    input  inst_t           held_inst,
    output op_class_t       op_class,
    output reg_idx_t        rd,
    output reg_idx_t        rs1,
    output reg_idx_t        rs2,
    output funct3_t         funct3,
    output logic [xlen-1:0] imm
);

    inst_t inst;
    opcode_t opcode;
    logic u_type;

    assign inst = held_valid ? held_inst : '0;   // empty slot decodes as zero
    assign opcode = get_opcode(inst);

    assign rd = get_rd(inst);
    assign rs1 = get_rs1(inst);
    assign rs2 = get_rs2(inst);
    assign funct3 = get_funct3(inst);

    always_comb begin
        op_class = '0;
        case (opcode)
            opc_lui: op_class[cls_lui] = 1'b1;
            opc_auipc: op_class[cls_auipc] = 1'b1;
            opc_jal: op_class[cls_jal] = 1'b1;
            opc_jalr: op_class[cls_jalr] = 1'b1;
            opc_branch: op_class[cls_branch] = 1'b1;
            opc_load: op_class[cls_load] = 1'b1;
            opc_store: op_class[cls_store] = 1'b1;
            opc_op_imm: op_class[cls_alu_i] = 1'b1;
            opc_op: op_class[cls_alu_r] = 1'b1;
            opc_op_imm32: op_class[cls_alu_iw] = 1'b1;
            opc_op32: op_class[cls_alu_rw] = 1'b1;
            opc_system: begin
                if (funct3 != 3'b000) begin
                    op_class[cls_csr] = 1'b1;   // csrrw and friends
                end else if (inst == inst_ebreak) begin
                    op_class[cls_ebreak] = 1'b1;
                end else if (inst == inst_ecall) begin
                    op_class[cls_ecall] = 1'b1;
                end else if (inst == inst_mret) begin
                    op_class[cls_mret] = 1'b1;
                end
            end
            default: op_class = '0;   // unknown opcode
        endcase
    end

    assign u_type = op_class[cls_lui] || op_class[cls_auipc];

    // all formats sign-extend from bit 31
    always_comb begin
        if (u_type) begin
            imm = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
        end else if (op_class[cls_jal]) begin
            imm = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};
        end else if (op_class[cls_branch]) begin
            imm = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};
        end else if (op_class[cls_store]) begin
            imm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
        end else begin
            imm = {{(xlen-12){inst[31]}}, inst[31:20]};   // i format, also unknown
        end
    end

endmodule

// ==== source/load_interlock.sv ====
module load_interlock
    import rv_isa_pkg::*;
(
    input  logic      held_valid,
    input  inst_t     held_inst,
    input  op_class_t held_class,
    input  logic      ex_valid,
    input  inst_t     ex_inst,
    output logic      block
);

    reg_idx_t ex_rd;
    logic ex_load;
    logic rs1_hit;
    logic rs2_hit;
    logic rs2_used;

    assign ex_rd = get_rd(ex_inst);
    assign ex_load = (get_opcode(ex_inst) == opc_load);

    // x0 is compared too
    assign rs1_hit = (ex_rd == get_rs1(held_inst));
    assign rs2_hit = (ex_rd == get_rs2(held_inst));

    // classes that read rs2 for this check, jal kept in the set
    assign rs2_used = held_class[cls_jal] || held_class[cls_jalr] ||
                      held_class[cls_branch] || held_class[cls_alu_r] ||
                      held_class[cls_alu_rw];

    assign block = held_valid && ex_valid && ex_load &&
                   (rs1_hit || (rs2_hit && rs2_used));

endmodule

// ==== source/issue_register.sv ====
module issue_register
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  in_valid,   // accepted this cycle
    input  addr_t in_pc,
    input  inst_t in_inst,
    input  logic  queue_empty,
    input  addr_t queue_pc,
    input  inst_t queue_inst,
    input  logic  advance,
    output logic  queue_write,
    output logic  queue_read,
    output logic  held_valid,
    output addr_t held_pc,
    output inst_t held_inst
);

    logic bypass;

    // nothing queued ahead and the slot moves, so skip the queue
    assign bypass = queue_empty && advance;
    assign queue_write = in_valid && !bypass;
    assign queue_read = advance && !queue_empty;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            held_valid <= 1'b0;
        end else if (advance) begin
            held_valid <= !queue_empty || in_valid;   // bubble if nothing to take
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (!queue_empty) begin
                held_pc <= queue_pc;   // oldest first
                held_inst <= queue_inst;
            end else if (in_valid) begin
                held_pc <= in_pc;
                held_inst <= in_inst;
            end
        end
    end

endmodule

// ==== source/inst_queue.sv ====
module inst_queue #(
    parameter type payload_t = logic [31:0],
    parameter int queue_depth = 16,
    parameter int almost_full_level = 12
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     write,
    input  payload_t write_data,
    input  logic     read,
    output payload_t read_data,
    output logic     almost_full,
    output logic     empty
);

    localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    payload_t mem [queue_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [count_width-1:0] count;   // occupancy
    logic full;
    logic do_write;
    logic do_read;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(queue_depth - 1)) begin
            return '0;   // wrap for any depth
        end
        return ptr + ptr_width'(1);
    endfunction

    assign full = (count == count_width'(queue_depth));
    assign empty = (count == '0);
    assign almost_full = (count >= count_width'(almost_full_level));
    assign do_write = write && !full;   // overflow dropped
    assign do_read = read && !empty;   // underflow dropped
    assign read_data = mem[rd_ptr];   // head, no read latency

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10: count <= count + count_width'(1);
                2'b01: count <= count - count_width'(1);
                default: count <= count;   // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= write_data;
        end
    end

endmodule

// ==== source/rv_csr_pkg.sv ====
package rv_csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // machine csrs visible to decode
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    // system instructions with no operand fields
    localparam logic [31:0] inst_ecall  = 32'h0000_0073;
    localparam logic [31:0] inst_ebreak = 32'h0010_0073;
    localparam logic [31:0] inst_mret   = 32'h3020_0073;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen = 64;
    localparam int inst_width = 32;
    localparam int opcode_width = 7;
    localparam int reg_idx_width = 5;
    localparam int reg_count = 1 << reg_idx_width;
    localparam int class_width = 15;

    typedef logic [inst_width-1:0] inst_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;
    typedef logic [opcode_width-1:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [class_width-1:0] op_class_t;   // one-hot, zero for unknown

    // bit positions in op_class_t
    localparam int cls_lui    = 0;
    localparam int cls_auipc  = 1;
    localparam int cls_jal    = 2;
    localparam int cls_jalr   = 3;
    localparam int cls_branch = 4;
    localparam int cls_load   = 5;
    localparam int cls_store  = 6;
    localparam int cls_alu_i  = 7;
    localparam int cls_alu_r  = 8;
    localparam int cls_alu_iw = 9;
    localparam int cls_alu_rw = 10;
    localparam int cls_csr    = 11;
    localparam int cls_ebreak = 12;
    localparam int cls_ecall  = 13;
    localparam int cls_mret   = 14;

    localparam opcode_t opc_load     = 7'b000_0011;
    localparam opcode_t opc_store    = 7'b010_0011;
    localparam opcode_t opc_branch   = 7'b110_0011;
    localparam opcode_t opc_jal      = 7'b110_1111;
    localparam opcode_t opc_jalr     = 7'b110_0111;
    localparam opcode_t opc_lui      = 7'b011_0111;
    localparam opcode_t opc_auipc    = 7'b001_0111;
    localparam opcode_t opc_op_imm   = 7'b001_0011;
    localparam opcode_t opc_op       = 7'b011_0011;
    localparam opcode_t opc_op_imm32 = 7'b001_1011;
    localparam opcode_t opc_op32     = 7'b011_1011;
    localparam opcode_t opc_system   = 7'b111_0011;

    function automatic opcode_t get_opcode(input inst_t inst);
        return inst[6:0];
    endfunction

    function automatic reg_idx_t get_rd(input inst_t inst);
        return inst[11:7];
    endfunction

    function automatic reg_idx_t get_rs1(input inst_t inst);
        return inst[19:15];
    endfunction

    function automatic reg_idx_t get_rs2(input inst_t inst);
        return inst[24:20];
    endfunction

    function automatic funct3_t get_funct3(input inst_t inst);
        return inst[14:12];
    endfunction

endpackage
